// ==== Makefile ====
TOP := tb_lenet
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/lenet_checker.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module lenet_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 busy,
    input  logic                 done,
    input  lenet_pkg::pool_out_t pool_out,
    input  logic                 test_end,
    output int                   value_errors,
    output int                   status_errors
);

    localparam int RESULTS_PER_RUN = `POOL_DIM*`POOL_DIM;

    logic [`DATA_W-1:0] stim [256];
    logic [`DATA_W-1:0] expected [$];
    int                 num_cases;
    int                 exp_ptr;
    int                 results_in_run;
    int                 runs_done;
    bit                 armed;          // set once reset has been clocked
    bit                 finished;
    bit                 prev_start, prev_busy, prev_valid, prev_done;

    // pull the expected pooled values out of the stimulus
    initial
    begin
        int                 ptr;
        logic [`DATA_W-1:0] flags;
        $readmemh("bench/lenet_stimulus.txt", stim);
        num_cases = int'(stim[0]);
        ptr = 1;
        for (int c = 0; c < num_cases; c++)
        begin
            flags = stim[ptr];
            ptr = ptr + 1;
            if (flags[0])
                ptr = ptr + `IMG_DIM*`IMG_DIM;
            ptr = ptr + `KER_TAPS + 1;
            for (int k = 0; k < RESULTS_PER_RUN; k++)
                expected.push_back(stim[ptr+k]);
            ptr = ptr + RESULTS_PER_RUN;
        end
    end

    always @(posedge clk)
    begin
        if (rst)
            armed <= 1'b1;
    end

    task automatic report_status(input string msg);
        $display("status error at %0t: %s", $time, msg);
        status_errors++;
    endtask

    task automatic inspect_reset();
        if (busy !== 1'b0 || done !== 1'b0 || pool_out.valid !== 1'b0)
            report_status("busy, done or pool_out valid not low during reset");
    endtask

    ////////////////////////////////////////////////////////////
    // result stream
    ////////////////////////////////////////////////////////////
    task automatic compare_result();
        if (!busy)
            report_status("pool_out valid while busy is low");
        if (results_in_run >= RESULTS_PER_RUN || exp_ptr >= expected.size())
            report_status("extra pool_out result beyond nine in this run");
        else
        begin
            if (pool_out.idx !== `POOL_IW'(results_in_run))
            begin
                $display("[FAIL] %0t pool_out.idx got %0d expected %0d",
                         $time, pool_out.idx, results_in_run);
                value_errors++;
            end
            if (pool_out.value !== expected[exp_ptr])
            begin
                $display("[FAIL] %0t pool_out.value got %h expected %h",
                         $time, pool_out.value, expected[exp_ptr]);
                value_errors++;
            end
            exp_ptr++;
        end
        results_in_run++;
    endtask

    task automatic close_run();
        if (prev_done)
            report_status("done held high for more than one cycle");
        else
        begin
            if (busy)
                report_status("busy still high in the done cycle");
            if (!prev_valid || results_in_run != RESULTS_PER_RUN)
                report_status("done did not follow the ninth result by one cycle");
            runs_done++;
            exp_ptr        = runs_done * RESULTS_PER_RUN;   // realign after a short run
            results_in_run = 0;
        end
    endtask

    task automatic watch_cycle();
        if (prev_start && !prev_busy && !busy)
            report_status("busy did not rise the cycle after start");
        if (!prev_busy && busy && !prev_start)
            report_status("busy rose without a start pulse");
        if (prev_busy && !busy && !done)
            report_status("busy fell without a done pulse");
        if (pool_out.valid)
            compare_result();
        if (done)
            close_run();
    endtask

    task automatic verify_totals();
        if (runs_done != num_cases)
            report_status($sformatf("expected %0d runs ending in done, saw %0d",
                                    num_cases, runs_done));
        if (results_in_run != 0)
            report_status("results arrived after the last done");
        if (busy)
            report_status("still busy at the end of the test");
        finished = 1'b1;
    endtask

    // sampled on the falling edge
    always @(negedge clk)
    begin
        if (armed && !finished)
        begin
            if (rst)
                inspect_reset();
            else
                watch_cycle();
            if (test_end)
                verify_totals();
            prev_start = start;
            prev_busy  = busy;
            prev_valid = pool_out.valid;
            prev_done  = done;
        end
    end

endmodule

// ==== bench/lenet_stimulus.txt ====
// case count first; per case: flags (bit0 new image, bit1 second start mid run),
// 64 pixels if bit0, 9 weights row-major, bias, 9 expected pooled values (Q8.8 hex)
0004
// case 1: ramp image, diagonal kernel 0.5 / 1 / 0.5, bias 3
0001
E000 E100 E200 E300 E400 E500 E600 E700
E800 E900 EA00 EB00 EC00 ED00 EE00 EF00
F000 F100 F200 F300 F400 F500 F600 F700
F800 F900 FA00 FB00 FC00 FD00 FE00 FF00
0000 0100 0200 0300 0400 0500 0600 0700
0800 0900 0A00 0B00 0C00 0D00 0E00 0F00
1000 1100 1200 1300 1400 1500 1600 1700
1800 1900 1A00 1B00 1C00 1D00 1E00 1F00
0080 0000 0000 0000 0100 0000 0000 0000 0080
0300
E700 EB00 EF00 0700 0B00 0F00 2700 2B00 2F00
// case 2: ramp image kept, new kernel and bias -2
0000
FF00 0000 0000 0000 0000 FF80 0000 0040 0000
FE00
2540 22C0 2040 1140 0EC0 0C40 FD40 FAC0 F840
// case 3: large image, box kernel, outputs clamp both ways
0001
6400 6400 6400 6400 0000 0000 0000 0000
6400 6400 6400 6400 0100 0100 0100 0100
6400 6400 6400 6400 0200 0200 0200 0200
0000 0000 0000 0000 0300 0300 0300 0300
0000 0000 0000 0000 0400 0400 0400 0400
9C00 9C00 9C00 9C00 0500 0500 0500 0500
9C00 9C00 9C00 9C00 0600 0600 0600 0600
9C00 9C00 9C00 9C00 0700 0700 0700 0700
0100 0100 0100 0100 0100 0100 0100 0100 0100
0000
7FFF 7FFF 1200 7FFF 7FFF 2400 8000 8000 3600
// case 4: large image kept, centre tap, bias 0.5, second start while busy
0002
0000 0000 0000 0000 0100 0000 0000 0000 0000
0080
6480 6480 0280 0080 0480 0480 9C80 0680 0680

// ==== bench/tb_lenet.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module tb_lenet;
    import lenet_pkg::*;

    logic      clk;
    logic      rst;
    logic      start;
    pix_wr_t   pix_wr;
    ker_wr_t   ker_wr;
    pool_out_t pool_out;
    logic      busy;
    logic      done;
    logic      test_end;
    int        value_errors;
    int        status_errors;

    logic [`DATA_W-1:0] stim [256];    // whole stimulus file, hex words
    int                 num_cases;
    int                 cycle_limit;
    int                 cycle_count;

    lenet_core i_lenet_core (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .pix_wr   (pix_wr),
        .ker_wr   (ker_wr),
        .pool_out (pool_out),
        .busy     (busy),
        .done     (done)
    );

    lenet_checker u_lenet_checker (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .pool_out      (pool_out),
        .test_end      (test_end),
        .value_errors  (value_errors),
        .status_errors (status_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    ////////////////////////////////////////////////////////////
    // driving helpers, inputs move 1 ns after the rising edge
    ////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_image(input int base);
        int i;
        for (i = 0; i < `IMG_DIM*`IMG_DIM; i++)
        begin
            pix_wr = '{valid: 1'b1, addr: `IMG_AW'(i), data: stim[base+i]};
            next_cycle();
        end
        pix_wr = '0;
    endtask

    // nine taps then the bias at index 9
    task automatic load_kernel(input int base);
        int i;
        for (i = 0; i <= `KER_TAPS; i++)
        begin
            ker_wr = '{valid: 1'b1, idx: `KER_IW'(i), data: stim[base+i]};
            next_cycle();
        end
        ker_wr = '0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done)
            @(negedge clk);
        next_cycle();
    endtask

    task automatic run_layers(input logic extra_start);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        if (extra_start)
        begin
            repeat (150) next_cycle();    // well inside the conv layer
            start = 1'b1;
            next_cycle();
            start = 1'b0;
        end
        wait_done();
        repeat (2) next_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        int                 ptr;
        logic [`DATA_W-1:0] flags;
        rst      = 1'b1;
        start    = 1'b0;
        pix_wr   = '0;
        ker_wr   = '0;
        test_end = 1'b0;
        $readmemh("bench/lenet_stimulus.txt", stim);
        num_cases   = int'(stim[0]);
        cycle_limit = num_cases * 600;    // load plus run, with margin
        repeat (5) next_cycle();
        rst = 1'b0;
        next_cycle();
        ptr = 1;
        for (int c = 0; c < num_cases; c++)
        begin
            flags = stim[ptr];
            ptr = ptr + 1;
            if (flags[0])
            begin
                load_image(ptr);
                ptr = ptr + `IMG_DIM*`IMG_DIM;
            end
            load_kernel(ptr);
            ptr = ptr + `KER_TAPS + 1;
            ptr = ptr + `POOL_DIM*`POOL_DIM;    // expected values, checker side
            run_layers(flags[1]);
        end
        test_end = 1'b1;
        @(negedge clk);
        #1;
        $display("closing: %0d value errors, %0d status errors", value_errors, status_errors);
        if (value_errors == 0 && status_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // cycle budget for the whole run
    initial
    begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: test did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/lenet_pkg.sv
src/layer_ctrl.sv
src/image_mem.sv
src/mac_unit.sv
src/conv_engine.sv
src/fmap_buffer.sv
src/pool_engine.sv
src/lenet_core.sv
bench/lenet_checker.sv
bench/tb_lenet.sv

// ==== src/conv_engine.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module conv_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 conv_start,
    input  lenet_pkg::ker_wr_t   ker_wr,
    output logic [`IMG_AW-1:0]   img_addr,
    input  logic [`DATA_W-1:0]   img_data,
    output lenet_pkg::fm_wr_t    fm_wr,
    output logic                 conv_done
);
    import lenet_pkg::*;

    localparam logic [2:0] POS_LAST = 3'(`FM_DIM - 1);
    localparam logic [1:0] KER_LAST = 2'(`KER_DIM - 1);

    logic [`DATA_W-1:0] weight [`KER_TAPS];
    logic [`DATA_W-1:0] bias_q;

    logic               running;
    logic [2:0]         orow, ocol;     // output position
    logic [1:0]         kr, kc;         // tap inside the window
    logic [`KER_IW-1:0] tap_idx;

    // issue stage, lines up with the returning pixel
    logic               iss_valid;
    logic               iss_first, iss_last;
    logic [`DATA_W-1:0] iss_wt;
    logic [`FM_AW-1:0]  iss_addr;

    mac_tap_t           tap;

    ////////////////////////////////////////////////////////////
    // kernel and bias registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (ker_wr.valid)
        begin
            if (ker_wr.idx == `KER_IW'(`KER_TAPS))
                bias_q <= ker_wr.data;
            else
                weight[ker_wr.idx] <= ker_wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // window walker, one tap per cycle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running <= 1'b0;
            orow    <= '0;
            ocol    <= '0;
            kr      <= '0;
            kc      <= '0;
        end
        else if (conv_start)
        begin
            running <= 1'b1;
            orow    <= '0;
            ocol    <= '0;
            kr      <= '0;
            kc      <= '0;
        end
        else if (running)
        begin
            if (kc != KER_LAST)
                kc <= kc + 2'd1;
            else
            begin
                kc <= '0;
                if (kr != KER_LAST)
                    kr <= kr + 2'd1;
                else
                begin
                    kr <= '0;
                    if (ocol != POS_LAST)
                        ocol <= ocol + 3'd1;
                    else
                    begin
                        ocol <= '0;
                        if (orow != POS_LAST)
                            orow <= orow + 3'd1;
                        else
                        begin
                            orow    <= '0;
                            running <= 1'b0;   // last tap of last window
                        end
                    end
                end
            end
        end
    end

    assign tap_idx  = `KER_IW'(kr * `KER_DIM + kc);
    assign img_addr = `IMG_AW'((orow + kr) * `IMG_DIM + (ocol + kc));

    always_ff @(posedge clk)
    begin
        if (rst)
            iss_valid <= 1'b0;
        else
            iss_valid <= running;
    end

    always_ff @(posedge clk)
    begin
        iss_first <= (kr == 2'd0) && (kc == 2'd0);
        iss_last  <= (kr == KER_LAST) && (kc == KER_LAST);
        iss_wt    <= weight[tap_idx];
        iss_addr  <= `FM_AW'(orow * `FM_DIM + ocol);
    end

    assign tap = '{valid: iss_valid, first: iss_first, last: iss_last,
                   pix: img_data, wt: iss_wt};

    mac_unit u_mac_unit (
        .clk      (clk),
        .rst      (rst),
        .tap      (tap),
        .bias     (bias_q),
        .out_addr (iss_addr),
        .fm_wr    (fm_wr)
    );

    // the write to the last entry ends the layer
    always_ff @(posedge clk)
    begin
        if (rst)
            conv_done <= 1'b0;
        else
            conv_done <= fm_wr.valid && (fm_wr.addr == `FM_AW'(`FM_DIM*`FM_DIM - 1));
    end

endmodule

// ==== src/fmap_buffer.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module fmap_buffer (
    input  logic                 clk,
    input  lenet_pkg::fm_wr_t    fm_wr,
    input  logic [`FM_AW-1:0]    rd_addr,
    output logic [`DATA_W-1:0]   rd_data
);

    // 6x6 conv result, raster order
    logic [`DATA_W-1:0] mem [`FM_DIM*`FM_DIM];

    always_ff @(posedge clk)
    begin
        if (fm_wr.valid)
        begin
            mem[fm_wr.addr] <= fm_wr.data;
        end
        rd_data <= mem[rd_addr];   // registered read
    end

endmodule

// ==== src/image_mem.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module image_mem (
    input  logic                 clk,
    input  lenet_pkg::pix_wr_t   pix_wr,
    input  logic [`IMG_AW-1:0]   rd_addr,
    output logic [`DATA_W-1:0]   rd_data
);

    // one word per pixel, row-major
    logic [`DATA_W-1:0] mem [`IMG_DIM*`IMG_DIM];

    always_ff @(posedge clk)
    begin
        if (pix_wr.valid)
        begin
            mem[pix_wr.addr] <= pix_wr.data;
        end
        rd_data <= mem[rd_addr];   // data one cycle after address
    end

endmodule

// ==== src/layer_ctrl.sv ====
`timescale 1ns/1ps

module layer_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic conv_done,
    input  logic pool_done,
    output logic conv_start,
    output logic pool_start,
    output logic busy,
    output logic done
);
    import lenet_pkg::*;

    layer_state_e state;

    ////////////////////////////////////////////////////////////
    // layer sequence: idle -> conv -> pool -> idle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= IDLE;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            conv_start <= 1'b0;    // all strobes are single cycle
            pool_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state      <= CONV;
                        conv_start <= 1'b1;
                    end
                end
                CONV:
                begin
                    if (conv_done)
                    begin
                        state      <= POOL;
                        pool_start <= 1'b1;
                    end
                end
                POOL:
                begin
                    if (pool_done)
                    begin
                        state <= IDLE;
                        done  <= 1'b1;     // busy drops on the same edge
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign busy = (state != IDLE);

endmodule

// ==== src/lenet_consts.svh ====
`ifndef LENET_CONSTS_SVH
`define LENET_CONSTS_SVH

// geometry of the two kept layers
`define IMG_DIM     8
`define KER_DIM     3
`define KER_TAPS    9
`define FM_DIM      6
`define POOL_DIM    3

// number format, Q8.8
`define DATA_W      16
`define FRAC_W      8
`define ACC_W       36      // nine 32-bit products plus headroom

// address and index sizes
`define IMG_AW      6
`define FM_AW       6
`define KER_IW      4       // taps 0..8, bias at 9
`define POOL_IW     4

`endif

// ==== src/lenet_core.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module lenet_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  lenet_pkg::pix_wr_t   pix_wr,
    input  lenet_pkg::ker_wr_t   ker_wr,
    output lenet_pkg::pool_out_t pool_out,
    output logic                 busy,
    output logic                 done
);
    import lenet_pkg::*;

    logic               conv_start, conv_done;
    logic               pool_start, pool_done;
    logic [`IMG_AW-1:0] img_addr;
    logic [`DATA_W-1:0] img_data;
    logic [`FM_AW-1:0]  fm_addr;
    logic [`DATA_W-1:0] fm_data;
    fm_wr_t             fm_wr;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////
    layer_ctrl u_layer_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .conv_done  (conv_done),
        .pool_done  (pool_done),
        .conv_start (conv_start),
        .pool_start (pool_start),
        .busy       (busy),
        .done       (done)
    );

    ////////////////////////////////////////////////////////////
    // conv layer: image -> feature map
    ////////////////////////////////////////////////////////////
    image_mem u_image_mem (
        .clk     (clk),
        .pix_wr  (pix_wr),
        .rd_addr (img_addr),
        .rd_data (img_data)
    );

    conv_engine u_conv_engine (
        .clk        (clk),
        .rst        (rst),
        .conv_start (conv_start),
        .ker_wr     (ker_wr),
        .img_addr   (img_addr),
        .img_data   (img_data),
        .fm_wr      (fm_wr),
        .conv_done  (conv_done)
    );

    fmap_buffer u_fmap_buffer (
        .clk     (clk),
        .fm_wr   (fm_wr),
        .rd_addr (fm_addr),
        .rd_data (fm_data)
    );

    // pool layer drains the buffer
    pool_engine u_pool_engine (
        .clk        (clk),
        .rst        (rst),
        .pool_start (pool_start),
        .fm_addr    (fm_addr),
        .fm_data    (fm_data),
        .pool_out   (pool_out),
        .pool_done  (pool_done)
    );

endmodule

// ==== src/lenet_pkg.sv ====
`include "lenet_consts.svh"

package lenet_pkg;

    // layer sequencer states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CONV = 2'd1,
        POOL = 2'd2
    } layer_state_e;

    typedef struct packed {
        logic                  valid;
        logic [`IMG_AW-1:0]    addr;
        logic [`DATA_W-1:0]    data;
    } pix_wr_t;

    typedef struct packed {
        logic                  valid;
        logic [`KER_IW-1:0]    idx;     // 0..8 taps row-major, 9 bias
        logic [`DATA_W-1:0]    data;
    } ker_wr_t;

    typedef struct packed {
        logic                  valid;
        logic [`FM_AW-1:0]     addr;
        logic [`DATA_W-1:0]    data;
    } fm_wr_t;

    // one product term on its way into the MAC
    typedef struct packed {
        logic                  valid;
        logic                  first;   // reload accumulator
        logic                  last;    // close the sum
        logic [`DATA_W-1:0]    pix;
        logic [`DATA_W-1:0]    wt;
    } mac_tap_t;

    typedef struct packed {
        logic                  valid;
        logic [`POOL_IW-1:0]   idx;     // raster index of the window
        logic [`DATA_W-1:0]    value;
    } pool_out_t;

endpackage

// ==== src/mac_unit.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module mac_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  lenet_pkg::mac_tap_t  tap,
    input  logic [`DATA_W-1:0]   bias,
    input  logic [`FM_AW-1:0]    out_addr,
    output lenet_pkg::fm_wr_t    fm_wr
);

    localparam logic signed [`ACC_W-1:0] SAT_MAX = (`ACC_W'(1) <<< (`DATA_W-1)) - 1;
    localparam logic signed [`ACC_W-1:0] SAT_MIN = -(`ACC_W'(1) <<< (`DATA_W-1));

    logic                          prod_valid, prod_first, prod_last;
    logic signed [2*`DATA_W-1:0]   prod;
    logic [`FM_AW-1:0]             addr_hold;

    logic signed [`ACC_W-1:0]      acc, acc_sum, biased, scaled;
    logic [`DATA_W-1:0]            sat_val;

    logic                          wr_valid;
    logic [`FM_AW-1:0]             wr_addr;
    logic [`DATA_W-1:0]            wr_data;

    // stage 1: product
    always_ff @(posedge clk)
    begin
        if (rst)
            prod_valid <= 1'b0;
        else
            prod_valid <= tap.valid;
    end

    always_ff @(posedge clk)
    begin
        prod       <= $signed(tap.pix) * $signed(tap.wt);
        prod_first <= tap.first;
        prod_last  <= tap.last;
        if (tap.valid && tap.last)
            addr_hold <= out_addr;      // destination of this sum
    end

    // bias is Q8.8, lift it to the Q16.16 product scale
    always_comb
    begin
        acc_sum = (prod_first ? '0 : acc) + `ACC_W'(prod);
        biased  = acc_sum + (`ACC_W'($signed(bias)) <<< `FRAC_W);
        scaled  = biased >>> `FRAC_W;
        if (scaled > SAT_MAX)
            sat_val = SAT_MAX[`DATA_W-1:0];
        else if (scaled < SAT_MIN)
            sat_val = SAT_MIN[`DATA_W-1:0];
        else
            sat_val = scaled[`DATA_W-1:0];
    end

    // stage 2: accumulate, close on last
    always_ff @(posedge clk)
    begin
        if (rst)
            wr_valid <= 1'b0;
        else
            wr_valid <= prod_valid && prod_last;
    end

    always_ff @(posedge clk)
    begin
        if (prod_valid)
            acc <= acc_sum;
        wr_addr <= addr_hold;
        wr_data <= sat_val;
    end

    assign fm_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

// ==== src/pool_engine.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module pool_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pool_start,
    output logic [`FM_AW-1:0]    fm_addr,
    input  logic [`DATA_W-1:0]   fm_data,
    output lenet_pkg::pool_out_t pool_out,
    output logic                 pool_done
);

    localparam logic [1:0] WIN_LAST = 2'(`POOL_DIM - 1);

    logic                   running;
    logic [1:0]             prow, pcol;    // window position
    logic [1:0]             sub;           // {row, col} inside the 2x2

    logic                   rd_valid, rd_first, rd_last;
    logic [`POOL_IW-1:0]    rd_idx;

    logic [`DATA_W-1:0]     run_max, cand;
    logic                   out_valid;
    logic [`POOL_IW-1:0]    out_idx;
    logic [`DATA_W-1:0]     out_value;

    ////////////////////////////////////////////////////////////
    // read walker, four reads per window
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running <= 1'b0;
            prow    <= '0;
            pcol    <= '0;
            sub     <= '0;
        end
        else if (pool_start)
        begin
            running <= 1'b1;
            prow    <= '0;
            pcol    <= '0;
            sub     <= '0;
        end
        else if (running)
        begin
            sub <= sub + 2'd1;
            if (sub == 2'd3)
            begin
                if (pcol != WIN_LAST)
                    pcol <= pcol + 2'd1;
                else
                begin
                    pcol <= '0;
                    if (prow != WIN_LAST)
                        prow <= prow + 2'd1;
                    else
                    begin
                        prow    <= '0;
                        running <= 1'b0;
                    end
                end
            end
        end
    end

    assign fm_addr = `FM_AW'((2*prow + sub[1]) * `FM_DIM + 2*pcol + sub[0]);

    always_ff @(posedge clk)
    begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= running;
    end

    always_ff @(posedge clk)
    begin
        rd_first <= (sub == 2'd0);
        rd_last  <= (sub == 2'd3);
        rd_idx   <= `POOL_IW'(prow * `POOL_DIM + pcol);
    end

    ////////////////////////////////////////////////////////////
    // running signed max
    ////////////////////////////////////////////////////////////
    assign cand = (rd_first || ($signed(fm_data) > $signed(run_max))) ? fm_data : run_max;

    always_ff @(posedge clk)
    begin
        if (rd_valid)
            run_max <= cand;
        out_idx   <= rd_idx;
        out_value <= cand;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            pool_done <= 1'b0;
        end
        else
        begin
            out_valid <= rd_valid && rd_last;
            pool_done <= rd_valid && rd_last
                         && (rd_idx == `POOL_IW'(`POOL_DIM*`POOL_DIM - 1));
        end
    end

    assign pool_out = '{valid: out_valid, idx: out_idx, value: out_value};

endmodule
